// File: cu_cache.f
+incdir+src
src/cache_req_pkg.sv
src/cache_issue_pkg.sv
src/cache_fifo.sv
src/cache_issue_ctrl.sv
src/cache_io_regs.sv
src/cu_cache.sv
verification/cu_cache_asserts.sv
verification/cu_cache_tb.sv

// File: src/cache_fifo.sv
// Head is valid whenever empty_o is low; push while full and pop while empty are dropped
`include "cu_cache_macros.svh"

module cache_fifo #(
  parameter int DEPTH       = `CACHE_FIFO_DEPTH,
  parameter int PROG_THRESH = `CACHE_PROG_THRESH,
  parameter int WIDTH       = `CACHE_DATA_W
) (
  input  logic             ap_clk      ,
  input  logic             areset_m_axi,
  input  logic             wr_en_i     ,
  input  logic [WIDTH-1:0] din_i       ,
  input  logic             rd_en_i     ,
  output logic [WIDTH-1:0] dout_o      ,
  output logic             full_o      ,
  output logic             empty_o     ,
  output logic             prog_full_o
);

  // --------------------------------------------------
  // Storage and pointers
  // --------------------------------------------------
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  logic [WIDTH-1:0] mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             push;
  logic             pop;

  // Wrap at DEPTH, works for any depth
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  // Qualified strobes
  assign push = wr_en_i & ~full_o;
  assign pop  = rd_en_i & ~empty_o;

  // --------------------------------------------------
  // Pointer and occupancy update
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else begin
      if (push) begin
        wr_ptr <= ptr_inc(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= ptr_inc(rd_ptr);
      end
      // Simultaneous push and pop leave the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Payload write, no reset on the array
  always_ff @(posedge ap_clk) begin
    if (push) begin
      mem[wr_ptr] <= din_i;
    end
  end

  // --------------------------------------------------
  // First-word-fall-through head and flags
  // --------------------------------------------------
  // Head shows the cycle after its push
  assign dout_o      = mem[rd_ptr];
  assign empty_o     = (count == '0);
  assign full_o      = (count == CNT_W'(DEPTH));
  assign prog_full_o = (count >= CNT_W'(PROG_THRESH));

endmodule : cache_fifo

// File: src/cache_io_regs.sv
// One cycle in and one out; requester must honour req_full_o, done needs every stage empty
`include "cu_cache_macros.svh"

module cache_io_regs (
  input  logic                        ap_clk           ,
  input  logic                        areset_m_axi     ,
  input  logic                        req_valid_i      ,
  input  cache_req_pkg::cache_cmd_e   req_cmd_i        ,
  input  cache_req_pkg::cache_addr_t  req_addr_i       ,
  input  cache_req_pkg::cache_data_t  req_wdata_i      ,
  input  logic [`CACHE_STRB_W-1:0]    req_wstrb_i      ,
  input  cache_req_pkg::cache_tag_t   req_tag_i        ,
  output logic                        req_fifo_wr_o    ,
  output cache_req_pkg::cache_req_t   req_fifo_din_o   ,
  input  logic                        req_fifo_empty_i ,
  input  logic                        resp_fifo_empty_i,
  input  cache_req_pkg::cache_resp_t  resp_fifo_dout_i ,
  output logic                        resp_fifo_rd_o   ,
  input  logic                        issue_idle_i     ,
  input  logic                        resp_pop_i       ,
  output logic                        resp_valid_o     ,
  output cache_req_pkg::cache_cmd_e   resp_cmd_o       ,
  output cache_req_pkg::cache_tag_t   resp_tag_o       ,
  output cache_req_pkg::cache_data_t  resp_rdata_o     ,
  output logic                        done_o
);

  import cache_req_pkg::*;

  logic       resp_load;
  logic       idle_now;
  logic       idle_q;

  // --------------------------------------------------
  // Request input register
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      req_fifo_wr_o <= 1'b0;
    end
    else begin
      req_fifo_wr_o <= req_valid_i;
    end
  end

  // Fields packed straight into the queue entry
  always_ff @(posedge ap_clk) begin
    req_fifo_din_o <= '{cmd: req_cmd_i, addr: req_addr_i, wdata: req_wdata_i,
                        wstrb: req_wstrb_i, tag: req_tag_i};
  end

  // --------------------------------------------------
  // Response output register
  // --------------------------------------------------
  // Refill when empty or being consumed this cycle
  assign resp_load      = ~resp_valid_o | resp_pop_i;
  assign resp_fifo_rd_o = resp_load & ~resp_fifo_empty_i;

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      resp_valid_o <= 1'b0;
    end
    else if (resp_load) begin
      resp_valid_o <= ~resp_fifo_empty_i;
    end
  end

  always_ff @(posedge ap_clk) begin
    if (resp_load) begin
      resp_cmd_o   <= resp_fifo_dout_i.cmd;
      resp_tag_o   <= resp_fifo_dout_i.tag;
      resp_rdata_o <= resp_fifo_dout_i.rdata;
    end
  end

  // --------------------------------------------------
  // Done detector
  // --------------------------------------------------
  // Queues empty, controller idle
  // Input and output stages also count as work
  assign idle_now = req_fifo_empty_i & resp_fifo_empty_i & issue_idle_i &
                    ~req_fifo_wr_o & ~resp_valid_o;

  // Two register stages
  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      idle_q <= 1'b0;
      done_o <= 1'b0;
    end
    else begin
      idle_q <= idle_now;
      done_o <= idle_q;
    end
  end

endmodule : cache_io_regs

// File: src/cache_issue_ctrl.sv
// Single outstanding access; fields held with avalid until ready, reads complete on rvalid
`include "cu_cache_macros.svh"

module cache_issue_ctrl (
  input  logic                                ap_clk          ,
  input  logic                                areset_m_axi    ,
  input  cache_req_pkg::cache_req_t           head_i          ,
  input  logic                                head_empty_i    ,
  output logic                                head_pop_o      ,
  input  logic                                issue_en_i      ,
  input  logic                                resp_prog_full_i,
  output logic                                resp_push_o     ,
  output cache_req_pkg::cache_resp_t          resp_din_o      ,
  output logic                                mem_avalid_o    ,
  output logic [`CACHE_ADDR_W-3:0]            mem_addr_o      ,
  output cache_req_pkg::cache_data_t          mem_wdata_o     ,
  output logic [`CACHE_STRB_W-1:0]            mem_wstrb_o     ,
  input  logic                                mem_ready_i     ,
  input  logic                                mem_rvalid_i    ,
  input  cache_req_pkg::cache_data_t          mem_rdata_i     ,
  output logic                                idle_o
);

  import cache_req_pkg::*;
  import cache_issue_pkg::*;

  // --------------------------------------------------
  // State and held request
  // --------------------------------------------------
  issue_state_e state;
  issue_state_e next_state;
  cache_req_t   req_q;
  cache_data_t  rdata_q;
  logic         start;
  logic         is_write;

  // Take the head only with room for its response
  assign start    = (state == ISSUE_IDLE) & ~head_empty_i & issue_en_i & ~resp_prog_full_i;
  assign is_write = (req_q.cmd == CMD_MEM_WRITE);

  always_comb begin
    next_state = state;
    case (state)
      ISSUE_IDLE: begin
        if (start) begin
          next_state = ISSUE_ADDR;
        end
      end
      ISSUE_ADDR: begin
        // Write completes on the ready cycle
        if (mem_ready_i) begin
          next_state = is_write ? ISSUE_PUSH : ISSUE_WAIT;
        end
      end
      ISSUE_WAIT: begin
        if (mem_rvalid_i) begin
          next_state = ISSUE_PUSH;
        end
      end
      default: begin
        next_state = ISSUE_IDLE;
      end
    endcase
  end

  always_ff @(posedge ap_clk) begin
    if (areset_m_axi) begin
      state <= ISSUE_IDLE;
    end
    else begin
      state <= next_state;
    end
  end

  // --------------------------------------------------
  // Payload capture
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    if (start) begin
      req_q <= head_i;
    end
    // Writes answer with zero data
    if ((state == ISSUE_ADDR) && mem_ready_i && is_write) begin
      rdata_q <= '0;
    end
    else if ((state == ISSUE_WAIT) && mem_rvalid_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  // --------------------------------------------------
  // Memory port and queue strobes
  // --------------------------------------------------
  assign head_pop_o   = start;
  assign mem_avalid_o = (state == ISSUE_ADDR);
  // Word address from the byte address
  assign mem_addr_o   = req_q.addr[`CACHE_ADDR_W-1:2];
  assign mem_wdata_o  = req_q.wdata;
  // No byte enables on a read
  assign mem_wstrb_o  = is_write ? req_q.wstrb : '0;

  assign resp_push_o = (state == ISSUE_PUSH);
  assign resp_din_o  = '{cmd: req_q.cmd, tag: req_q.tag, rdata: rdata_q};
  assign idle_o      = (state == ISSUE_IDLE);

endmodule : cache_issue_ctrl

// File: src/cache_issue_pkg.sv
// Issue FSM encoding only; one access in flight at a time, the states cycle in order
package cache_issue_pkg;

  // --------------------------------------------------
  // Issue controller states
  // --------------------------------------------------
  // IDLE  waits for a head to take
  // ADDR  holds the access until ready
  // WAIT  read only, waits for rvalid
  // PUSH  writes the response entry
  typedef enum logic [1:0] {
    ISSUE_IDLE = 2'd0,
    ISSUE_ADDR = 2'd1,
    ISSUE_WAIT = 2'd2,
    ISSUE_PUSH = 2'd3
  } issue_state_e;

endpackage : cache_issue_pkg

// File: src/cache_req_pkg.sv
// Request entry is 77 bits and response entry 41 bits; field widths come from the macros header
`include "cu_cache_macros.svh"

package cache_req_pkg;

  // --------------------------------------------------
  // Command encoding
  // --------------------------------------------------
  typedef enum logic {
    CMD_MEM_READ  = 1'b0,
    CMD_MEM_WRITE = 1'b1
  } cache_cmd_e;

  // Field words
  typedef logic [`CACHE_ADDR_W-1:0] cache_addr_t;
  typedef logic [`CACHE_DATA_W-1:0] cache_data_t;
  typedef logic [`CACHE_TAG_W-1:0]  cache_tag_t;

  // --------------------------------------------------
  // Queue entries
  // --------------------------------------------------
  // Request queue entry, cmd in the top bit
  typedef struct packed {
    cache_cmd_e               cmd;
    cache_addr_t              addr;
    cache_data_t              wdata;
    logic [`CACHE_STRB_W-1:0] wstrb;
    cache_tag_t               tag;
  } cache_req_t;

  // Response queue entry, rdata zero for writes
  typedef struct packed {
    cache_cmd_e  cmd;
    cache_tag_t  tag;
    cache_data_t rdata;
  } cache_resp_t;

endpackage : cache_req_pkg

// File: src/cu_cache.sv
// Memory port is a bare word port with one access in flight; responses leave in request order
`include "cu_cache_macros.svh"

module cu_cache (
  input  logic                        ap_clk         ,
  input  logic                        areset_m_axi   ,
  input  logic                        req_valid_i    ,
  input  cache_req_pkg::cache_cmd_e   req_cmd_i      ,
  input  cache_req_pkg::cache_addr_t  req_addr_i     ,
  input  cache_req_pkg::cache_data_t  req_wdata_i    ,
  input  logic [`CACHE_STRB_W-1:0]    req_wstrb_i    ,
  input  cache_req_pkg::cache_tag_t   req_tag_i      ,
  input  logic                        req_issue_en_i ,
  input  logic                        resp_pop_i     ,
  output logic                        req_full_o     ,
  output logic                        req_prog_full_o,
  output logic                        resp_valid_o   ,
  output cache_req_pkg::cache_cmd_e   resp_cmd_o     ,
  output cache_req_pkg::cache_tag_t   resp_tag_o     ,
  output cache_req_pkg::cache_data_t  resp_rdata_o   ,
  output logic                        mem_avalid_o   ,
  output logic [`CACHE_ADDR_W-3:0]    mem_addr_o     ,
  output cache_req_pkg::cache_data_t  mem_wdata_o    ,
  output logic [`CACHE_STRB_W-1:0]    mem_wstrb_o    ,
  input  logic                        mem_ready_i    ,
  input  logic                        mem_rvalid_i   ,
  input  cache_req_pkg::cache_data_t  mem_rdata_i    ,
  output logic                        done_o
);

  import cache_req_pkg::*;

  // --------------------------------------------------
  // Request path wires
  // --------------------------------------------------
  logic        req_fifo_wr;
  cache_req_t  req_fifo_din;
  cache_req_t  req_fifo_dout;
  logic        req_fifo_rd;
  logic        req_fifo_empty;

  // Response path wires
  logic        resp_fifo_wr;
  cache_resp_t resp_fifo_din;
  cache_resp_t resp_fifo_dout;
  logic        resp_fifo_rd;
  logic        resp_fifo_empty;
  logic        resp_fifo_prog_full;
  logic        issue_idle;

  // --------------------------------------------------
  // Register stage and done detector
  // --------------------------------------------------
  cache_io_regs u_io_regs (
    .ap_clk           (ap_clk         ),
    .areset_m_axi     (areset_m_axi   ),
    .req_valid_i      (req_valid_i    ),
    .req_cmd_i        (req_cmd_i      ),
    .req_addr_i       (req_addr_i     ),
    .req_wdata_i      (req_wdata_i    ),
    .req_wstrb_i      (req_wstrb_i    ),
    .req_tag_i        (req_tag_i      ),
    .req_fifo_wr_o    (req_fifo_wr    ),
    .req_fifo_din_o   (req_fifo_din   ),
    .req_fifo_empty_i (req_fifo_empty ),
    .resp_fifo_empty_i(resp_fifo_empty),
    .resp_fifo_dout_i (resp_fifo_dout ),
    .resp_fifo_rd_o   (resp_fifo_rd   ),
    .issue_idle_i     (issue_idle     ),
    .resp_pop_i       (resp_pop_i     ),
    .resp_valid_o     (resp_valid_o   ),
    .resp_cmd_o       (resp_cmd_o     ),
    .resp_tag_o       (resp_tag_o     ),
    .resp_rdata_o     (resp_rdata_o   ),
    .done_o           (done_o         )
  );

  // --------------------------------------------------
  // Request queue
  // --------------------------------------------------
  cache_fifo #(
    .DEPTH      (`CACHE_FIFO_DEPTH  ),
    .PROG_THRESH(`CACHE_PROG_THRESH ),
    .WIDTH      ($bits(cache_req_t) )
  ) req_fifo (
    .ap_clk      (ap_clk         ),
    .areset_m_axi(areset_m_axi   ),
    .wr_en_i     (req_fifo_wr    ),
    .din_i       (req_fifo_din   ),
    .rd_en_i     (req_fifo_rd    ),
    .dout_o      (req_fifo_dout  ),
    .full_o      (req_full_o     ),
    .empty_o     (req_fifo_empty ),
    .prog_full_o (req_prog_full_o)
  );

  // --------------------------------------------------
  // Issue controller
  // --------------------------------------------------
  cache_issue_ctrl u_issue_ctrl (
    .ap_clk          (ap_clk             ),
    .areset_m_axi    (areset_m_axi       ),
    .head_i          (req_fifo_dout      ),
    .head_empty_i    (req_fifo_empty     ),
    .head_pop_o      (req_fifo_rd        ),
    .issue_en_i      (req_issue_en_i     ),
    .resp_prog_full_i(resp_fifo_prog_full),
    .resp_push_o     (resp_fifo_wr       ),
    .resp_din_o      (resp_fifo_din      ),
    .mem_avalid_o    (mem_avalid_o       ),
    .mem_addr_o      (mem_addr_o         ),
    .mem_wdata_o     (mem_wdata_o        ),
    .mem_wstrb_o     (mem_wstrb_o        ),
    .mem_ready_i     (mem_ready_i        ),
    .mem_rvalid_i    (mem_rvalid_i       ),
    .mem_rdata_i     (mem_rdata_i        ),
    .idle_o          (issue_idle         )
  );

  // --------------------------------------------------
  // Response queue
  // --------------------------------------------------
  // Full never reached, issue stalls at prog-full
  cache_fifo #(
    .DEPTH      (`CACHE_FIFO_DEPTH  ),
    .PROG_THRESH(`CACHE_PROG_THRESH ),
    .WIDTH      ($bits(cache_resp_t))
  ) resp_fifo (
    .ap_clk      (ap_clk             ),
    .areset_m_axi(areset_m_axi       ),
    .wr_en_i     (resp_fifo_wr       ),
    .din_i       (resp_fifo_din      ),
    .rd_en_i     (resp_fifo_rd       ),
    .dout_o      (resp_fifo_dout     ),
    .full_o      (                   ),
    .empty_o     (resp_fifo_empty    ),
    .prog_full_o (resp_fifo_prog_full)
  );

endmodule : cu_cache

// File: src/cu_cache_macros.svh
// Widths assume a 32-bit word memory port; FIFO depth must be above the prog-full threshold
`ifndef CU_CACHE_MACROS_SVH
`define CU_CACHE_MACROS_SVH

// --------------------------------------------------
// Request and response field widths
// --------------------------------------------------
// Byte address, the memory port drops the low 2 bits
`define CACHE_ADDR_W 32

// One data word per access
`define CACHE_DATA_W 32

// One strobe bit per byte lane
`define CACHE_STRB_W 4

// Requester tag, returned untouched
`define CACHE_TAG_W 8

// --------------------------------------------------
// Queue sizing
// --------------------------------------------------
// Entries in each queue
`define CACHE_FIFO_DEPTH 16

// Prog-full level, also the issue stall level
// Must leave room for the one access in flight
`define CACHE_PROG_THRESH 12

`endif

// File: verification/cu_cache_asserts.sv
// Bound into cache_issue_ctrl; the checks rely on that FSM keeping one memory access in flight
`include "cu_cache_macros.svh"

module cu_cache_asserts (
  input logic                          ap_clk          ,
  input logic                          areset_m_axi    ,
  input cache_issue_pkg::issue_state_e state_i         ,
  input logic                          head_pop_i      ,
  input cache_req_pkg::cache_cmd_e     head_cmd_i      ,
  input logic                          mem_avalid_i    ,
  input logic                          mem_ready_i     ,
  input logic [`CACHE_ADDR_W-3:0]      mem_addr_i      ,
  input cache_req_pkg::cache_data_t    mem_wdata_i     ,
  input logic [`CACHE_STRB_W-1:0]      mem_wstrb_i     ,
  input logic                          resp_push_i     ,
  input logic                          resp_prog_full_i
);

  timeunit 1ns;
  timeprecision 1ps;

  import cache_req_pkg::*;
  import cache_issue_pkg::*;

  // Assertion failures so far
  int unsigned fail_count = 0;

  // --------------------------------------------------
  // Memory port
  // --------------------------------------------------
  // Fields frozen while the access waits for ready
  a_fields_stable : assert property (
    @(posedge ap_clk) disable iff (areset_m_axi)
    mem_avalid_i && !mem_ready_i |=>
      mem_avalid_i && $stable(mem_addr_i) && $stable(mem_wdata_i) && $stable(mem_wstrb_i)
  ) else begin
    fail_count++;
    $error("memory request fields changed before mem_ready");
  end

  // A read taken from the queue goes out with no byte enables
  a_read_no_strobe : assert property (
    @(posedge ap_clk) disable iff (areset_m_axi)
    head_pop_i && (head_cmd_i == CMD_MEM_READ) |=>
      (state_i == ISSUE_ADDR) && (mem_wstrb_i == '0)
  ) else begin
    fail_count++;
    $error("read access presented a nonzero write strobe");
  end

  // --------------------------------------------------
  // Response queue
  // --------------------------------------------------
  // Prog-full sits below full, so this also rules out overflow
  a_no_push_full : assert property (
    @(posedge ap_clk) disable iff (areset_m_axi)
    resp_push_i |-> !resp_prog_full_i
  ) else begin
    fail_count++;
    $error("response pushed while the response queue was at its full level");
  end

endmodule : cu_cache_asserts

bind cache_issue_ctrl cu_cache_asserts u_asserts (
  .ap_clk          (ap_clk          ),
  .areset_m_axi    (areset_m_axi    ),
  .state_i         (state           ),
  .head_pop_i      (head_pop_o      ),
  .head_cmd_i      (head_i.cmd      ),
  .mem_avalid_i    (mem_avalid_o    ),
  .mem_ready_i     (mem_ready_i     ),
  .mem_addr_i      (mem_addr_o      ),
  .mem_wdata_i     (mem_wdata_o     ),
  .mem_wstrb_i     (mem_wstrb_o     ),
  .resp_push_i     (resp_push_o     ),
  .resp_prog_full_i(resp_prog_full_i)
);

// File: verification/cu_cache_patterns.txt
# cmd addr wdata wstrb tag exp_rdata mode, all hex except mode
# cmd 0 read 1 write; mode 0 streaming, 1 responses held, 2 issue disabled
1 00000010 11223344 f 01 00000000 0
0 00000010 00000000 0 02 11223344 0
1 00000010 aabbccdd 5 03 00000000 0
0 00000010 00000000 0 04 11bb33dd 0
1 00000024 cafef00d c 05 00000000 0
0 00000024 00000000 0 06 cafe0000 0
0 00000030 00000000 0 07 00000000 0
1 00000030 12345678 3 08 00000000 0
1 00000030 9abcdef0 8 09 00000000 0
0 00000030 00000000 0 0a 9a005678 0
1 00000040 b0b00000 f 10 00000000 1
1 00000044 b0b00001 f 11 00000000 1
1 00000048 b0b00002 f 12 00000000 1
1 0000004c b0b00003 f 13 00000000 1
1 00000050 b0b00004 f 14 00000000 1
1 00000054 b0b00005 f 15 00000000 1
1 00000058 b0b00006 f 16 00000000 1
1 0000005c b0b00007 f 17 00000000 1
1 00000060 b0b00008 f 18 00000000 1
1 00000064 b0b00009 f 19 00000000 1
1 00000068 b0b0000a f 1a 00000000 1
1 0000006c b0b0000b f 1b 00000000 1
1 00000070 b0b0000c 6 1c 00000000 1
0 00000040 00000000 0 1d b0b00000 1
0 00000044 00000000 0 1e b0b00001 1
0 00000048 00000000 0 1f b0b00002 1
0 0000004c 00000000 0 20 b0b00003 1
0 00000050 00000000 0 21 b0b00004 1
0 00000054 00000000 0 22 b0b00005 1
0 00000058 00000000 0 23 b0b00006 1
0 0000005c 00000000 0 24 b0b00007 1
0 00000060 00000000 0 25 b0b00008 1
0 00000064 00000000 0 26 b0b00009 1
0 00000068 00000000 0 27 b0b0000a 1
0 0000006c 00000000 0 28 b0b0000b 1
0 00000070 00000000 0 29 00b00000 1
0 00000010 00000000 0 2a 11bb33dd 2
1 00000024 0000beef 3 2b 00000000 2
0 00000024 00000000 0 2c cafebeef 2
0 00000070 00000000 0 2d 00b00000 2
1 00000000 ffffffff 1 2e 00000000 0
0 00000000 00000000 0 2f 000000ff 0

// File: verification/cu_cache_tb.sv
// Run from the project root for the patterns path; the memory model takes a nonzero strobe as a write
`include "cu_cache_macros.svh"

module cu_cache_tb;

  timeunit 1ns;
  timeprecision 1ps;

  import cache_req_pkg::*;

  localparam int MAX_PAT   = 64;
  localparam int TIMEOUT   = 2000;
  localparam int MEM_WORDS = 256;

  // --------------------------------------------------
  // DUT signals
  // --------------------------------------------------
  logic                     ap_clk;
  logic                     areset_m_axi;
  logic                     req_valid_i;
  cache_cmd_e               req_cmd_i;
  cache_addr_t              req_addr_i;
  cache_data_t              req_wdata_i;
  logic [`CACHE_STRB_W-1:0] req_wstrb_i;
  cache_tag_t               req_tag_i;
  logic                     req_issue_en_i;
  logic                     resp_pop_i;
  logic                     req_full_o;
  logic                     req_prog_full_o;
  logic                     resp_valid_o;
  cache_cmd_e               resp_cmd_o;
  cache_tag_t               resp_tag_o;
  cache_data_t              resp_rdata_o;
  logic                     mem_avalid_o;
  logic [`CACHE_ADDR_W-3:0] mem_addr_o;
  cache_data_t              mem_wdata_o;
  logic [`CACHE_STRB_W-1:0] mem_wstrb_o;
  logic                     mem_ready_i;
  logic                     mem_rvalid_i;
  cache_data_t              mem_rdata_i;
  logic                     done_o;

  // Pattern table, one entry per request
  logic [0:0]               pat_cmd   [MAX_PAT];
  cache_addr_t              pat_addr  [MAX_PAT];
  cache_data_t              pat_wdata [MAX_PAT];
  logic [`CACHE_STRB_W-1:0] pat_wstrb [MAX_PAT];
  cache_tag_t               pat_tag   [MAX_PAT];
  cache_data_t              pat_rdata [MAX_PAT];
  int                       pat_mode  [MAX_PAT];
  int                       pat_count = 0;

  // Memory behind the port
  cache_data_t mem_words [MEM_WORDS];
  logic [31:0] lfsr = 32'h422c_ac13;

  // Scoreboard counters
  int check_count    = 0;
  int mismatch_count = 0;
  int timeout_count  = 0;
  int other_count    = 0;
  int resp_count     = 0;

  cu_cache dut (.*);

  // --------------------------------------------------
  // Clock
  // --------------------------------------------------
  initial begin : clock_gen
    ap_clk = 1'b0;
    forever begin
      #50 ap_clk = ~ap_clk;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic int unsigned take_bits(input int n);
    int unsigned v;
    v = 0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic string mode_name(input int mode);
    case (mode)
      1:       return "held";
      2:       return "issue_off";
      default: return "stream";
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("Error %s: expected %h, actual %h", name, expected, actual);
    end
  endtask

  task automatic finish_run();
    int unsigned assert_fails;
    assert_fails = dut.u_issue_ctrl.u_asserts.fail_count;
    $display("Checks %0d, mismatches %0d, timeouts %0d, other failures %0d, assertion failures %0d",
             check_count, mismatch_count, timeout_count, other_count, assert_fails);
    if (mismatch_count == 0 && timeout_count == 0 && other_count == 0 && assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end
    else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  endtask

  task automatic report_timeout(input string what);
    timeout_count++;
    $display("Timeout: %s not seen within %0d cycles", what, TIMEOUT);
    finish_run();
  endtask

  task automatic read_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] f_cmd;
    logic [31:0] f_addr;
    logic [31:0] f_wdata;
    logic [31:0] f_wstrb;
    logic [31:0] f_tag;
    logic [31:0] f_rdata;
    int          f_mode;
    fd = $fopen("verification/cu_cache_patterns.txt", "r");
    if (fd == 0) begin
      other_count++;
      $display("Could not open verification/cu_cache_patterns.txt");
      finish_run();
    end
    else begin
      while (!$feof(fd) && pat_count < MAX_PAT) begin
        n = $fgets(line, fd);
        // Skip comment and blank lines
        if (n > 0 && line.getc(0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %d",
                      f_cmd, f_addr, f_wdata, f_wstrb, f_tag, f_rdata, f_mode);
          if (n == 7) begin
            pat_cmd[pat_count]   = f_cmd[0];
            pat_addr[pat_count]  = f_addr;
            pat_wdata[pat_count] = f_wdata;
            pat_wstrb[pat_count] = f_wstrb[`CACHE_STRB_W-1:0];
            pat_tag[pat_count]   = f_tag[`CACHE_TAG_W-1:0];
            pat_rdata[pat_count] = f_rdata;
            pat_mode[pat_count]  = f_mode;
            pat_count++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // One-cycle strobe, then a gap so req_full_o catches up
  task automatic push_request(input int i);
    int t;
    t = 0;
    @(negedge ap_clk);
    while (req_full_o && t < TIMEOUT) begin
      @(negedge ap_clk);
      t++;
    end
    if (req_full_o) begin
      report_timeout("request queue space");
    end
    else begin
      req_valid_i = 1'b1;
      req_cmd_i   = cache_cmd_e'(pat_cmd[i]);
      req_addr_i  = pat_addr[i];
      req_wdata_i = pat_wdata[i];
      // Reads present every strobe lane so the DUT has to mask them
      if (pat_cmd[i] == 1'b1) begin
        req_wstrb_i = pat_wstrb[i];
      end
      else begin
        req_wstrb_i = '1;
      end
      req_tag_i   = pat_tag[i];
      @(negedge ap_clk);
      req_valid_i = 1'b0;
    end
  endtask

  // Level wait on done_o or req_prog_full_o
  task automatic wait_flag(input bit use_done, input string what);
    int t;
    t = 0;
    while (!(use_done ? done_o : req_prog_full_o) && t < TIMEOUT) begin
      @(negedge ap_clk);
      t++;
    end
    if (!(use_done ? done_o : req_prog_full_o)) begin
      report_timeout(what);
    end
  endtask

  task automatic wait_responses(input int target);
    int t;
    t = 0;
    while (resp_count < target && t < TIMEOUT) begin
      @(negedge ap_clk);
      t++;
    end
    if (resp_count < target) begin
      report_timeout($sformatf("response %0d", target - 1));
    end
  endtask

  // --------------------------------------------------
  // Request groups
  // --------------------------------------------------
  task automatic run_group(input int first, input int last, input int mode);
    resp_pop_i     = (mode != 1);
    req_issue_en_i = (mode != 2);
    for (int i = first; i <= last; i++) begin
      push_request(i);
    end
    if (mode == 1) begin
      // Stalled issue backs requests up into the request queue
      wait_flag(1'b0, "request queue prog-full");
      check_value("held resp_valid", 1, resp_valid_o);
      check_value("held resp_count", first, resp_count);
      // Work still queued
      check_value("held done", 0, done_o);
      resp_pop_i = 1'b1;
    end
    if (mode == 2) begin
      repeat (8) @(negedge ap_clk);
      check_value("issue_off resp_count", first, resp_count);
      req_issue_en_i = 1'b1;
    end
    wait_responses(last + 1);
  endtask

  // --------------------------------------------------
  // Memory model
  // --------------------------------------------------
  initial begin : mem_model
    logic [7:0]               idx;
    cache_data_t              wdata;
    logic [`CACHE_STRB_W-1:0] wstrb;
    forever begin
      @(negedge ap_clk);
      if (mem_avalid_o) begin
        // Random ready delay of 0 to 3 cycles
        repeat (take_bits(2)) @(negedge ap_clk);
        idx         = mem_addr_o[7:0];
        wdata       = mem_wdata_o;
        wstrb       = mem_wstrb_o;
        mem_ready_i = 1'b1;
        @(negedge ap_clk);
        mem_ready_i = 1'b0;
        if (wstrb != '0) begin
          for (int b = 0; b < `CACHE_STRB_W; b++) begin
            if (wstrb[b]) begin
              mem_words[idx][8*b +: 8] = wdata[8*b +: 8];
            end
          end
        end
        else begin
          repeat (take_bits(2)) @(negedge ap_clk);
          mem_rvalid_i = 1'b1;
          mem_rdata_i  = mem_words[idx];
          @(negedge ap_clk);
          mem_rvalid_i = 1'b0;
          // Junk outside rvalid to catch early capture
          mem_rdata_i  = 32'hdead_beef;
        end
      end
    end
  end

  // --------------------------------------------------
  // Response and issue monitors
  // --------------------------------------------------
  // A response is consumed on each edge with valid and pop high
  initial begin : resp_checker
    string name;
    forever begin
      @(posedge ap_clk);
      if (!areset_m_axi && resp_valid_o && resp_pop_i) begin
        if (resp_count >= pat_count) begin
          other_count++;
          $display("Unexpected response with tag %h after the last request", resp_tag_o);
        end
        else begin
          name = $sformatf("%s rsp %0d", mode_name(pat_mode[resp_count]), resp_count);
          check_value({name, " cmd"}, pat_cmd[resp_count], resp_cmd_o);
          check_value({name, " tag"}, pat_tag[resp_count], resp_tag_o);
          check_value({name, " rdata"}, pat_rdata[resp_count], resp_rdata_o);
        end
        resp_count++;
      end
    end
  end

  initial begin : issue_watch
    forever begin
      @(posedge ap_clk);
      if (!areset_m_axi && !req_issue_en_i) begin
        check_value("issue_off mem_avalid", 0, mem_avalid_o);
      end
    end
  end

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin : main_seq
    int first;
    int last;
    areset_m_axi   = 1'b1;
    req_valid_i    = 1'b0;
    req_cmd_i      = CMD_MEM_READ;
    req_addr_i     = '0;
    req_wdata_i    = '0;
    req_wstrb_i    = '0;
    req_tag_i      = '0;
    req_issue_en_i = 1'b1;
    resp_pop_i     = 1'b1;
    mem_ready_i    = 1'b0;
    mem_rvalid_i   = 1'b0;
    mem_rdata_i    = 32'hdead_beef;
    for (int w = 0; w < MEM_WORDS; w++) begin
      mem_words[w] = '0;
    end
    read_patterns();
    if (pat_count == 0) begin
      other_count++;
      $display("No request lines found in the patterns file");
    end
    // Reset for 5 cycles
    repeat (5) @(negedge ap_clk);
    areset_m_axi = 1'b0;
    @(negedge ap_clk);
    check_value("reset resp_valid", 0, resp_valid_o);
    check_value("reset mem_avalid", 0, mem_avalid_o);
    check_value("reset done", 0, done_o);
    check_value("reset req_full", 0, req_full_o);
    wait_flag(1'b1, "done after reset");
    // Consecutive lines of one mode form a group
    first = 0;
    while (first < pat_count) begin
      last = first;
      while (last + 1 < pat_count && pat_mode[last + 1] == pat_mode[first]) begin
        last++;
      end
      run_group(first, last, pat_mode[first]);
      first = last + 1;
    end
    wait_flag(1'b1, "done after the last response");
    check_value("final resp_valid", 0, resp_valid_o);
    finish_run();
  end

endmodule : cu_cache_tb
